/* Makefile */
SIM      = verilator
TOP      = tb_uart
FILELIST = project.f
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
PASS     = PASS: all tests
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^$(PASS)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* project.f */
uart_pkg.sv
uart_fifo_if.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
tb_clock_gen.sv
tb_uart.sv

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic test_tx_clk,
	output logic arst_n
);

	// 100 ns period
	initial
	begin
		test_tx_clk = 1'b0;
		forever
			#50 test_tx_clk = ~test_tx_clk;
	end

	// released on a falling edge, clear of the stimulus edge
	initial
	begin
		arst_n = 1'b0;
		repeat (16)
			@(negedge test_tx_clk);
		arst_n = 1'b1;
	end

endmodule

/* tb_uart.sv */
`timescale 1ns/1ps

module tb_uart;

	typedef struct packed {
		logic [7:0] data;
		logic       par_bit;
		logic       perr;
		logic       s1err;
		logic       s2err;
	} frame_t;

	localparam int wait_limit = 400;
	localparam int drain_limit = 5000;

	logic       test_tx_clk;
	logic       arst_n;
	logic [1:0] cfg_data_bits;
	logic       cfg_parity_en;
	logic       cfg_even_parity;
	logic       cfg_two_stop;
	logic [7:0] tx_data;
	logic       tx_write;
	logic       tx_full;
	logic       sout;
	logic       sin_drv;
	logic       sin_line;
	logic       loop_en;
	logic       rx_read;
	logic       rx_empty;
	logic [7:0] rx_data;
	logic       rx_parity_err;
	logic       rx_stop1_err;
	logic       rx_stop2_err;
	logic       rx_overrun;

	int     seed;
	frame_t tx_exp[$];
	frame_t tx_got[$];
	frame_t rx_exp[$];
	frame_t rx_got[$];

	tb_clock_gen clk_gen (
		.test_tx_clk (test_tx_clk),
		.arst_n      (arst_n)
	);

	// loopback ties sout back to sin
	assign sin_line = loop_en ? sout : sin_drv;

	uart_top UUT (
		.test_tx_clk     (test_tx_clk),
		.arst_n          (arst_n),
		.cfg_data_bits   (cfg_data_bits),
		.cfg_parity_en   (cfg_parity_en),
		.cfg_even_parity (cfg_even_parity),
		.cfg_two_stop    (cfg_two_stop),
		.tx_data         (tx_data),
		.tx_write        (tx_write),
		.tx_full         (tx_full),
		.sout            (sout),
		.sin             (sin_line),
		.rx_read         (rx_read),
		.rx_empty        (rx_empty),
		.rx_data         (rx_data),
		.rx_parity_err   (rx_parity_err),
		.rx_stop1_err    (rx_stop1_err),
		.rx_stop2_err    (rx_stop2_err),
		.rx_overrun      (rx_overrun)
	);

	////////////////////
	// reference model
	////////////////////

	// par_bit is the level on the line, after any deliberate flip
	function automatic frame_t frame_ref(input logic [7:0] b, input logic [1:0] code,
		input logic par_en, input logic even, input logic two_stop,
		input logic flip_par, input logic stop1_low, input logic stop2_low);
		frame_t f;
		logic [7:0] mask;
		mask = 8'hff >> (3 - code);
		f.data = b & mask;
		f.par_bit = par_en ? ((^f.data) ^ !even ^ flip_par) : 1'b0;
		f.perr = par_en & flip_par;
		f.s1err = stop1_low;
		f.s2err = two_stop & stop2_low;
		return f;
	endfunction

	////////////////////
	// checking
	////////////////////

	task automatic stop_on_failure();
		$display("FAIL: see errors above");
		$fatal(1, "test stopped at first error");
	endtask

	task automatic fail_now(input string what);
		$display("error: %0t ns, %s", $time, what);
		stop_on_failure();
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("error: %0t ns, %s = %0h, expected %0h", $time, name, got, exp);
			stop_on_failure();
		end
	endtask

	initial
	begin : compare_proc
		frame_t got;
		frame_t exp;
		forever
		begin
			@(posedge test_tx_clk);
			while (tx_got.size() > 0)
			begin
				got = tx_got.pop_front();
				if (tx_exp.size() == 0)
					fail_now("a frame appeared on sout with none expected");
				else
				begin
					exp = tx_exp.pop_front();
					check_value("sout data", 32'(got.data), 32'(exp.data));
					check_value("sout parity bit", 32'(got.par_bit), 32'(exp.par_bit));
					check_value("sout stop1 low", 32'(got.s1err), 32'(exp.s1err));
					check_value("sout stop2 low", 32'(got.s2err), 32'(exp.s2err));
				end
			end
			while (rx_got.size() > 0)
			begin
				got = rx_got.pop_front();
				if (rx_exp.size() == 0)
					fail_now("a character was read with none expected");
				else
				begin
					exp = rx_exp.pop_front();
					check_value("rx_data", 32'(got.data), 32'(exp.data));
					check_value("rx_parity_err", 32'(got.perr), 32'(exp.perr));
					check_value("rx_stop1_err", 32'(got.s1err), 32'(exp.s1err));
					check_value("rx_stop2_err", 32'(got.s2err), 32'(exp.s2err));
				end
			end
		end
	end

	////////////////////
	// sout monitor
	////////////////////

	// one bit period of falling-edge samples, steady when all agree
	task automatic sample_bit(output logic v, output logic steady);
		int i;
		logic first;
		@(negedge test_tx_clk);
		first = sout;
		steady = 1'b1;
		for (i = 1; i < uart_pkg::bit_clks; i++)
		begin
			@(negedge test_tx_clk);
			if (sout !== first)
				steady = 1'b0;
		end
		v = first;
	endtask

	initial
	begin : sout_monitor
		frame_t f;
		logic v;
		logic steady;
		logic shape_ok;
		int n;
		int i;
		forever
		begin
			@(negedge test_tx_clk);
			if (arst_n && !sout)
			begin
				shape_ok = 1'b1;
				f = '0;
				n = 32'(cfg_data_bits) + 5;
				// rest of the start bit
				for (i = 1; i < uart_pkg::bit_clks; i++)
				begin
					@(negedge test_tx_clk);
					if (sout)
						shape_ok = 1'b0;
				end
				for (i = 0; i < n; i++)
				begin
					sample_bit(v, steady);
					f.data[i] = v;
					shape_ok = shape_ok & steady;
				end
				if (cfg_parity_en)
				begin
					sample_bit(v, steady);
					f.par_bit = v;
					shape_ok = shape_ok & steady;
				end
				sample_bit(v, steady);
				f.s1err = !(v && steady);
				if (cfg_two_stop)
				begin
					sample_bit(v, steady);
					f.s2err = !(v && steady);
				end
				check_value("sout bit shape", 32'(shape_ok), 32'd1);
				tx_got.push_back(f);
			end
		end
	end

	////////////////////
	// stimulus tasks
	////////////////////

	// pmode 0 none, 1 even, 2 odd
	task automatic set_cfg(input int code, input int pmode, input int stop);
		cfg_data_bits = code[1:0];
		cfg_parity_en = (pmode != 0);
		cfg_even_parity = (pmode == 1);
		cfg_two_stop = stop[0];
	endtask

	task automatic write_tx(input logic [7:0] b);
		int t;
		t = 0;
		while (tx_full && t < wait_limit)
		begin
			@(posedge test_tx_clk);
			#1;
			t++;
		end
		if (tx_full)
			fail_now("tx_full never cleared");
		else
		begin
			tx_data = b;
			tx_write = 1'b1;
			tx_exp.push_back(frame_ref(b, cfg_data_bits, cfg_parity_en,
				cfg_even_parity, cfg_two_stop, 1'b0, 1'b0, 1'b0));
			@(posedge test_tx_clk);
			#1;
			tx_write = 1'b0;
		end
	endtask

	task automatic read_rx();
		int t;
		frame_t f;
		t = 0;
		while (rx_empty && t < wait_limit)
		begin
			@(posedge test_tx_clk);
			#1;
			t++;
		end
		if (rx_empty)
			fail_now("no character arrived in the receive buffer");
		else
		begin
			f.data = rx_data;
			f.par_bit = 1'b0;
			f.perr = rx_parity_err;
			f.s1err = rx_stop1_err;
			f.s2err = rx_stop2_err;
			rx_got.push_back(f);
			rx_read = 1'b1;
			@(posedge test_tx_clk);
			#1;
			rx_read = 1'b0;
		end
	endtask

	task automatic expect_rx(input logic [7:0] b, input logic flip_par,
		input logic stop1_low, input logic stop2_low);
		frame_t f;
		f = frame_ref(b, cfg_data_bits, cfg_parity_en, cfg_even_parity,
			cfg_two_stop, flip_par, stop1_low, stop2_low);
		f.par_bit = 1'b0;
		rx_exp.push_back(f);
	endtask

	task automatic drive_bit(input logic v);
		sin_drv = v;
		repeat (uart_pkg::bit_clks)
			@(posedge test_tx_clk);
		#1;
	endtask

	// ends with two idle bits so a low stop bit cannot run into the next start
	task automatic send_frame(input logic [7:0] b, input logic flip_par,
		input logic stop1_low, input logic stop2_low);
		frame_t f;
		int n;
		int i;
		f = frame_ref(b, cfg_data_bits, cfg_parity_en, cfg_even_parity,
			cfg_two_stop, flip_par, stop1_low, stop2_low);
		n = 32'(cfg_data_bits) + 5;
		drive_bit(1'b0);
		for (i = 0; i < n; i++)
			drive_bit(b[i]);
		if (cfg_parity_en)
			drive_bit(f.par_bit);
		drive_bit(!stop1_low);
		if (cfg_two_stop)
			drive_bit(!stop2_low);
		drive_bit(1'b1);
		drive_bit(1'b1);
	endtask

	task automatic receive_one(input logic flip_par, input logic stop1_low,
		input logic stop2_low);
		int rnd;
		rnd = $random(seed);
		expect_rx(rnd[7:0], flip_par, stop1_low, stop2_low);
		send_frame(rnd[7:0], flip_par, stop1_low, stop2_low);
		read_rx();
	endtask

	task automatic wait_drained();
		int t;
		t = 0;
		while ((tx_exp.size() + tx_got.size() + rx_exp.size() + rx_got.size()) != 0 &&
			t < drain_limit)
		begin
			@(posedge test_tx_clk);
			#1;
			t++;
		end
		if ((tx_exp.size() + tx_got.size() + rx_exp.size() + rx_got.size()) != 0)
			fail_now("expected characters were still outstanding at the timeout");
	endtask

	////////////////////
	// test sequence
	////////////////////

	initial
	begin : stimulus
		int code;
		int pmode;
		int stop;
		int i;
		int j;
		int t;
		int rnd;
		int accepted;
		seed = 32'hf3d8_ae83;
		set_cfg(3, 0, 0);
		tx_data = 8'h00;
		tx_write = 1'b0;
		sin_drv = 1'b1;
		loop_en = 1'b0;
		rx_read = 1'b0;

		t = 0;
		while (!arst_n && t < wait_limit)
		begin
			@(posedge test_tx_clk);
			#1;
			t++;
		end
		if (!arst_n)
			fail_now("reset was never released");
		check_value("sout", 32'(sout), 32'd1);
		check_value("tx_full", 32'(tx_full), 32'd0);
		check_value("rx_empty", 32'(rx_empty), 32'd1);
		check_value("rx_overrun", 32'(rx_overrun), 32'd0);

		// every width, parity and stop setting on both paths
		for (code = 0; code < 4; code++)
			for (pmode = 0; pmode < 3; pmode++)
				for (stop = 0; stop < 2; stop++)
				begin
					set_cfg(code, pmode, stop);
					for (i = 0; i < 2; i++)
					begin
						rnd = $random(seed);
						write_tx(rnd[7:0]);
					end
					wait_drained();
					for (i = 0; i < 2; i++)
						receive_one(1'b0, 1'b0, 1'b0);
					wait_drained();
				end

		// each corrupt frame followed by a clean one
		for (stop = 0; stop < 2; stop++)
		begin
			set_cfg(3, stop + 1, stop);
			receive_one(1'b1, 1'b0, 1'b0);
			receive_one(1'b0, 1'b0, 1'b0);
			receive_one(1'b0, 1'b1, 1'b0);
			receive_one(1'b0, 1'b0, 1'b0);
			if (stop == 1)
			begin
				receive_one(1'b0, 1'b0, 1'b1);
				receive_one(1'b0, 1'b0, 1'b0);
			end
			wait_drained();
		end

		// write every cycle until the transmit FIFO fills
		set_cfg(3, 0, 0);
		accepted = 0;
		i = 0;
		while (!tx_full && i < 4 * uart_pkg::fifo_depth)
		begin
			rnd = $random(seed);
			tx_data = rnd[7:0];
			tx_write = 1'b1;
			tx_exp.push_back(frame_ref(tx_data, cfg_data_bits, cfg_parity_en,
				cfg_even_parity, cfg_two_stop, 1'b0, 1'b0, 1'b0));
			accepted++;
			@(posedge test_tx_clk);
			#1;
			i++;
		end
		for (i = 0; i < 3; i++)
		begin
			check_value("tx_full", 32'(tx_full), 32'd1);
			rnd = $random(seed);
			tx_data = rnd[7:0];
			@(posedge test_tx_clk);
			#1;
		end
		tx_write = 1'b0;
		check_value("accepted tx writes", accepted, uart_pkg::fifo_depth + 1);
		wait_drained();

		// one frame more than the receive FIFO holds
		for (i = 0; i <= uart_pkg::fifo_depth; i++)
		begin
			rnd = $random(seed);
			if (i < uart_pkg::fifo_depth)
				expect_rx(rnd[7:0], 1'b0, 1'b0, 1'b0);
			else
				check_value("rx_overrun", 32'(rx_overrun), 32'd0);
			send_frame(rnd[7:0], 1'b0, 1'b0, 1'b0);
		end
		check_value("rx_overrun", 32'(rx_overrun), 32'd1);
		for (i = 0; i < uart_pkg::fifo_depth; i++)
			read_rx();
		check_value("rx_empty", 32'(rx_empty), 32'd1);
		wait_drained();

		// loopback stream
		set_cfg(3, 1, 0);
		loop_en = 1'b1;
		fork
			begin
				for (i = 0; i < 12; i++)
				begin
					rnd = $random(seed);
					expect_rx(rnd[7:0], 1'b0, 1'b0, 1'b0);
					write_tx(rnd[7:0]);
				end
			end
			begin
				for (j = 0; j < 12; j++)
					read_rx();
			end
		join
		wait_drained();

		$display("PASS: all tests");
		$finish;
	end

endmodule

/* uart_fifo.sv */
`timescale 1ns/1ps

module uart_fifo #(
	parameter int width = 8
) (
	input  logic         test_tx_clk,
	input  logic         arst_n,
	uart_fifo_if.store   port
);

	logic [width-1:0] mem [uart_pkg::fifo_depth];

	logic [uart_pkg::fifo_ptr_w-1:0] wr_ptr;
	logic [uart_pkg::fifo_ptr_w-1:0] rd_ptr;
	logic [uart_pkg::fifo_cnt_w-1:0] count;

	logic do_push;
	logic do_pop;

	// strobes against a full or empty buffer are dropped
	assign do_push = port.push && !port.full;
	assign do_pop = port.pop && !port.empty;

	assign port.full = (count == uart_pkg::fifo_full_cnt);
	assign port.empty = (count == '0);

	// first word falls through
	assign port.rdata = mem[rd_ptr];

	always_ff @(posedge test_tx_clk)
	begin
		if (do_push)
			mem[wr_ptr] <= port.wdata;
	end

	always_ff @(posedge test_tx_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
			begin
				if (wr_ptr == uart_pkg::fifo_ptr_last)
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end

			if (do_pop)
			begin
				if (rd_ptr == uart_pkg::fifo_ptr_last)
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end

			// simultaneous push and pop leaves the level alone
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	a_count_bound: assert property (
		@(posedge test_tx_clk) disable iff (!arst_n)
		count <= uart_pkg::fifo_full_cnt
	) else $error("fifo occupancy above depth");

endmodule

/* uart_fifo_if.sv */
`timescale 1ns/1ps

interface uart_fifo_if #(
	parameter int width = 8
) ();

	// write side
	logic             push;
	logic [width-1:0] wdata;
	logic             full;

	// read side, rdata is valid whenever empty is low
	logic             pop;
	logic [width-1:0] rdata;
	logic             empty;

	modport writer (
		output push,
		output wdata,
		input  full
	);

	modport reader (
		output pop,
		input  rdata,
		input  empty
	);

	modport store (
		input  push,
		input  wdata,
		output full,
		input  pop,
		output rdata,
		output empty
	);

endinterface

/* uart_pkg.sv */
package uart_pkg;

	////////////////////
	// bit timing
	////////////////////

	// clocks per serial bit
	localparam int bit_clks = 16;
	// start edge to mid-bit sample point
	localparam int half_bit_clks = 8;
	localparam int bit_cnt_w = $clog2(bit_clks);

	// terminal counts for the bit-period counters
	localparam logic [bit_cnt_w-1:0] bit_last = bit_cnt_w'(bit_clks - 1);
	localparam logic [bit_cnt_w-1:0] half_last = bit_cnt_w'(half_bit_clks - 1);

	////////////////////
	// buffering
	////////////////////

	localparam int fifo_depth = 8;
	localparam int fifo_ptr_w = $clog2(fifo_depth);
	// one extra bit so a full buffer can be counted
	localparam int fifo_cnt_w = $clog2(fifo_depth + 1);

	localparam logic [fifo_ptr_w-1:0] fifo_ptr_last = fifo_ptr_w'(fifo_depth - 1);
	localparam logic [fifo_cnt_w-1:0] fifo_full_cnt = fifo_cnt_w'(fifo_depth);

	////////////////////
	// state machines
	////////////////////

	typedef enum logic [2:0] {
		tx_idle,
		tx_start,
		tx_data,
		tx_parity,
		tx_stop1,
		tx_stop2
	} tx_state_t;

	typedef enum logic [2:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_parity,
		rx_stop1,
		rx_stop2
	} rx_state_t;

	// one received character with its error flags
	// data bits above the configured width read as zero
	typedef struct packed {
		logic [7:0] data;
		logic       parity_err;
		logic       stop1_err;
		logic       stop2_err;
	} rx_char_t;

	localparam int rx_char_w = $bits(rx_char_t);

endpackage

/* uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
	input  logic         test_tx_clk,
	input  logic         arst_n,
	input  logic [1:0]   cfg_data_bits,
	input  logic         cfg_parity_en,
	input  logic         cfg_even_parity,
	input  logic         cfg_two_stop,
	input  logic         sin,
	uart_fifo_if.writer  fifo,
	output logic         overrun
);

	uart_pkg::rx_state_t state;
	uart_pkg::rx_char_t  rx_char;

	logic       sin_meta;
	logic       sin_s;
	logic [uart_pkg::bit_cnt_w-1:0] cnt;
	logic [2:0] idx;
	logic [2:0] idx_last;
	logic [7:0] data;
	logic       par;
	logic       perr;
	logic       stop1_err;
	logic       mid;
	logic       last_sample;

	// two flops against metastability, line idles high
	always_ff @(posedge test_tx_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			sin_meta <= 1'b1;
			sin_s <= 1'b1;
		end
		else
		begin
			sin_meta <= sin;
			sin_s <= sin_meta;
		end
	end

	assign idx_last = {1'b0, cfg_data_bits} + 3'd4;

	// half a bit to the start check, a full bit between later samples
	assign mid = (state == uart_pkg::rx_start) ? (cnt == uart_pkg::half_last) :
		(cnt == uart_pkg::bit_last);

	assign last_sample = mid &&
		((state == uart_pkg::rx_stop2) ||
		(state == uart_pkg::rx_stop1 && !cfg_two_stop));

	////////////////////
	// character build
	////////////////////

	// the final stop flag comes straight from the current sample
	always_comb
	begin
		rx_char.data = data;
		rx_char.parity_err = perr;
		rx_char.stop1_err = (state == uart_pkg::rx_stop1) ? !sin_s : stop1_err;
		rx_char.stop2_err = (state == uart_pkg::rx_stop2) && !sin_s;
	end

	assign fifo.wdata = rx_char;
	assign fifo.push = last_sample && !fifo.full;

	always_ff @(posedge test_tx_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= uart_pkg::rx_idle;
			cnt <= '0;
			idx <= '0;
			par <= 1'b0;
			perr <= 1'b0;
			stop1_err <= 1'b0;
			overrun <= 1'b0;
		end
		else
		begin
			if (state == uart_pkg::rx_idle || mid)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;

			// sticky until reset
			if (last_sample && fifo.full)
				overrun <= 1'b1;

			case (state)
				uart_pkg::rx_idle:
				begin
					if (!sin_s)
						state <= uart_pkg::rx_start;
				end
				uart_pkg::rx_start:
				begin
					if (mid)
					begin
						// high at mid start bit means a glitch
						state <= sin_s ? uart_pkg::rx_idle : uart_pkg::rx_data;
						idx <= '0;
						par <= 1'b0;
						perr <= 1'b0;
					end
				end
				uart_pkg::rx_data:
				begin
					if (mid)
					begin
						par <= par ^ sin_s;
						idx <= idx + 1'b1;
						if (idx == idx_last)
							state <= cfg_parity_en ? uart_pkg::rx_parity : uart_pkg::rx_stop1;
					end
				end
				uart_pkg::rx_parity:
				begin
					if (mid)
					begin
						perr <= sin_s != (cfg_even_parity ? par : ~par);
						state <= uart_pkg::rx_stop1;
					end
				end
				uart_pkg::rx_stop1:
				begin
					if (mid)
					begin
						stop1_err <= !sin_s;
						state <= cfg_two_stop ? uart_pkg::rx_stop2 : uart_pkg::rx_idle;
					end
				end
				uart_pkg::rx_stop2:
				begin
					if (mid)
						state <= uart_pkg::rx_idle;
				end
				default:
				begin
					state <= uart_pkg::rx_idle;
				end
			endcase
		end
	end

	// cleared on each confirmed start so unused high bits stay zero
	always_ff @(posedge test_tx_clk)
	begin
		if (state == uart_pkg::rx_start && mid)
			data <= '0;
		else if (state == uart_pkg::rx_data && mid)
			data[idx] <= sin_s;
	end

	a_push_in_stop: assert property (
		@(posedge test_tx_clk) disable iff (!arst_n)
		fifo.push |-> (state == uart_pkg::rx_stop1 || state == uart_pkg::rx_stop2)
	) else $error("receive push outside a stop bit");

endmodule

/* uart_top.sv */
`timescale 1ns/1ps

module uart_top (
	input  logic       test_tx_clk,
	input  logic       arst_n,
	input  logic [1:0] cfg_data_bits,
	input  logic       cfg_parity_en,
	input  logic       cfg_even_parity,
	input  logic       cfg_two_stop,
	input  logic [7:0] tx_data,
	input  logic       tx_write,
	output logic       tx_full,
	output logic       sout,
	input  logic       sin,
	input  logic       rx_read,
	output logic       rx_empty,
	output logic [7:0] rx_data,
	output logic       rx_parity_err,
	output logic       rx_stop1_err,
	output logic       rx_stop2_err,
	output logic       rx_overrun
);

	uart_fifo_if #(.width(8)) tx_if ();
	uart_fifo_if #(.width(uart_pkg::rx_char_w)) rx_if ();

	uart_pkg::rx_char_t rx_head;

	////////////////////
	// host side
	////////////////////

	assign tx_if.push = tx_write;
	assign tx_if.wdata = tx_data;
	assign tx_full = tx_if.full;

	assign rx_if.pop = rx_read;
	assign rx_empty = rx_if.empty;

	// oldest received character, split into its fields
	assign rx_head = uart_pkg::rx_char_t'(rx_if.rdata);
	assign rx_data = rx_head.data;
	assign rx_parity_err = rx_head.parity_err;
	assign rx_stop1_err = rx_head.stop1_err;
	assign rx_stop2_err = rx_head.stop2_err;

	////////////////////
	// datapath
	////////////////////

	uart_fifo #(.width(8)) tx_fifo (
		.test_tx_clk (test_tx_clk),
		.arst_n      (arst_n),
		.port        (tx_if.store)
	);

	uart_tx u_tx (
		.test_tx_clk     (test_tx_clk),
		.arst_n          (arst_n),
		.cfg_data_bits   (cfg_data_bits),
		.cfg_parity_en   (cfg_parity_en),
		.cfg_even_parity (cfg_even_parity),
		.cfg_two_stop    (cfg_two_stop),
		.fifo            (tx_if.reader),
		.sout            (sout)
	);

	uart_rx u_rx (
		.test_tx_clk     (test_tx_clk),
		.arst_n          (arst_n),
		.cfg_data_bits   (cfg_data_bits),
		.cfg_parity_en   (cfg_parity_en),
		.cfg_even_parity (cfg_even_parity),
		.cfg_two_stop    (cfg_two_stop),
		.sin             (sin),
		.fifo            (rx_if.writer),
		.overrun         (rx_overrun)
	);

	uart_fifo #(.width(uart_pkg::rx_char_w)) rx_fifo (
		.test_tx_clk (test_tx_clk),
		.arst_n      (arst_n),
		.port        (rx_if.store)
	);

endmodule

/* uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
	input  logic         test_tx_clk,
	input  logic         arst_n,
	input  logic [1:0]   cfg_data_bits,
	input  logic         cfg_parity_en,
	input  logic         cfg_even_parity,
	input  logic         cfg_two_stop,
	uart_fifo_if.reader  fifo,
	output logic         sout
);

	uart_pkg::tx_state_t state;

	logic [uart_pkg::bit_cnt_w-1:0] cnt;
	logic [2:0] idx;
	logic [2:0] idx_last;
	logic [7:0] shreg;
	logic       par;
	logic       bit_end;
	logic       frame_end;

	// code 0..3 means 5..8 data bits
	assign idx_last = {1'b0, cfg_data_bits} + 3'd4;
	assign bit_end = (cnt == uart_pkg::bit_last);

	assign frame_end = bit_end &&
		((state == uart_pkg::tx_stop2) ||
		(state == uart_pkg::tx_stop1 && !cfg_two_stop));

	// refill at the end of the last stop bit keeps frames back to back
	assign fifo.pop = !fifo.empty && ((state == uart_pkg::tx_idle) || frame_end);

	////////////////////
	// frame sequencing
	////////////////////

	always_ff @(posedge test_tx_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= uart_pkg::tx_idle;
			cnt <= '0;
			idx <= '0;
			par <= 1'b0;
		end
		else if (fifo.pop)
		begin
			state <= uart_pkg::tx_start;
			cnt <= '0;
		end
		else
		begin
			if (state == uart_pkg::tx_idle || bit_end)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;

			case (state)
				uart_pkg::tx_start:
				begin
					if (bit_end)
					begin
						state <= uart_pkg::tx_data;
						idx <= '0;
						par <= 1'b0;
					end
				end
				uart_pkg::tx_data:
				begin
					if (bit_end)
					begin
						par <= par ^ shreg[0];
						idx <= idx + 1'b1;
						if (idx == idx_last)
							state <= cfg_parity_en ? uart_pkg::tx_parity : uart_pkg::tx_stop1;
					end
				end
				uart_pkg::tx_parity:
				begin
					if (bit_end)
						state <= uart_pkg::tx_stop1;
				end
				uart_pkg::tx_stop1:
				begin
					if (bit_end)
						state <= cfg_two_stop ? uart_pkg::tx_stop2 : uart_pkg::tx_idle;
				end
				uart_pkg::tx_stop2:
				begin
					if (bit_end)
						state <= uart_pkg::tx_idle;
				end
				default:
				begin
					state <= uart_pkg::tx_idle;
				end
			endcase
		end
	end

	// lsb goes out first
	always_ff @(posedge test_tx_clk)
	begin
		if (fifo.pop)
			shreg <= fifo.rdata;
		else if (state == uart_pkg::tx_data && bit_end)
			shreg <= {1'b0, shreg[7:1]};
	end

	////////////////////
	// line driver
	////////////////////

	always_comb
	begin
		case (state)
			uart_pkg::tx_start:  sout = 1'b0;
			uart_pkg::tx_data:   sout = shreg[0];
			uart_pkg::tx_parity: sout = cfg_even_parity ? par : ~par;
			default:             sout = 1'b1;
		endcase
	end

	a_idle_mark: assert property (
		@(posedge test_tx_clk) disable iff (!arst_n)
		(state == uart_pkg::tx_idle) |-> sout
	) else $error("sout low while transmitter idle");

endmodule
